/* build.f */
+incdir+hdl
hdl/cam_pkg.sv
hdl/vga_pkg.sv
hdl/ov7670_capture.sv
hdl/frame_buffer.sv
hdl/vga_sync.sv
hdl/vga_display.sv
hdl/top_ov7670.sv
verif/tb_top_ov7670.sv

/* Makefile */
# Verilator build and run for the ov7670 capture and vga display project

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -sv -Wno-fatal
TOP       = tb_top_ov7670
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = test passed
FAIL_MSG  = test failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/tb_top_ov7670.sv */
// testbench for top_ov7670 that drives camera frames and checks the vga picture
`include "ov_cfg.svh"

module tb_top_ov7670;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int c_hs_clks    = `H_SYNC * `CLKS_PER_PXL;
  localparam int c_de_clks    = `H_VISIBLE * `CLKS_PER_PXL;
  localparam int c_vs_clks    = `V_SYNC * `H_TOTAL * `CLKS_PER_PXL;
  localparam int c_pic_clks   = 2 * `IMG_PXLS * `CLKS_PER_PXL;  // two checked frames
  localparam int c_vs_timeout = 2 * `H_TOTAL * `V_TOTAL * `CLKS_PER_PXL;

  logic       clk       = 1'b0;
  logic       rst_n     = 1'b0;
  logic       cam_pclk  = 1'b0;
  logic       cam_href  = 1'b0;
  logic       cam_vsync = 1'b0;
  logic [7:0] cam_data  = 8'h00;
  logic [3:0] vga_red;
  logic [3:0] vga_green;
  logic [3:0] vga_blue;
  logic       vga_hsync;
  logic       vga_vsync;
  logic       vga_de;

  logic [15:0]      lfsr_q = 16'd38;
  cam_pkg::rgb444_t model [`IMG_ROWS][`IMG_COLS];  // expected picture
  logic             check_pic = 1'b0;

  int err_reset   = 0;
  int err_sync    = 0;
  int err_pic     = 0;
  int err_border  = 0;
  int err_cover   = 0;
  int err_timeout = 0;

  // beam follower state, all sampled on the falling edge
  logic de_q;
  logic vs_q;
  logic hs_q;
  int   line_cnt;    // de rises since vsync rose
  int   de_clks;     // clocks since de rose
  int   hs_low;
  int   vs_low;
  int   post_rst;
  int   pic_clks;

  logic             de_rise;
  logic             vs_rise;
  int               cur_row;
  int               cur_col;
  logic             in_img;
  logic             rst_window;
  logic [11:0]      rgb;
  cam_pkg::rgb444_t exp_pxl;

  always #20 clk = ~clk;

  top_ov7670 UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cam_pclk  (cam_pclk),
    .cam_href  (cam_href),
    .cam_vsync (cam_vsync),
    .cam_data  (cam_data),
    .vga_red   (vga_red),
    .vga_green (vga_green),
    .vga_blue  (vga_blue),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_de    (vga_de)
  );

  assign de_rise    = vga_de && !de_q;
  assign vs_rise    = vga_vsync && !vs_q;
  assign cur_row    = de_rise ? line_cnt : line_cnt - 1;
  assign cur_col    = (de_rise ? 0 : de_clks) / `CLKS_PER_PXL;
  assign in_img     = (cur_row >= 0) && (cur_row < `IMG_ROWS) && (cur_col < `IMG_COLS);
  assign rst_window = !rst_n || (post_rst < 4);
  assign rgb        = {vga_red, vga_green, vga_blue};

  always_comb begin
    exp_pxl = '0;
    if (in_img) exp_pxl = model[cur_row][cur_col];
  end

  always_ff @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      de_q     <= 1'b0;
      vs_q     <= 1'b1;
      hs_q     <= 1'b1;
      line_cnt <= 0;
      de_clks  <= 0;
      hs_low   <= 0;
      vs_low   <= 0;
      post_rst <= 0;
      pic_clks <= 0;
    end else begin
      de_q <= vga_de;
      vs_q <= vga_vsync;
      hs_q <= vga_hsync;
      if (vs_rise) line_cnt <= 0;
      else if (de_rise) line_cnt <= line_cnt + 1;
      if (de_rise) de_clks <= 1;
      else if (vga_de) de_clks <= de_clks + 1;
      if (!vga_hsync) hs_low <= hs_q ? 1 : hs_low + 1;
      if (!vga_vsync) vs_low <= vs_q ? 1 : vs_low + 1;
      if (post_rst < 4) post_rst <= post_rst + 1;
      if (check_pic && vga_de && in_img) pic_clks <= pic_clks + 1;
    end
  end

  a_reset_state: assert property (@(negedge clk)
    rst_window |-> ({vga_hsync, vga_vsync, vga_de, rgb} == 15'h6000))
    else begin
      err_reset++;
      $display("mismatch time %0t signal {vga_hsync,vga_vsync,vga_de,rgb} expected %h actual %h",
               $time, 15'h6000, $sampled({vga_hsync, vga_vsync, vga_de, rgb}));
    end

  a_hsync_width: assert property (@(negedge clk) disable iff (!rst_n)
    (vga_hsync && !hs_q) |-> (hs_low == c_hs_clks))
    else begin
      err_sync++;
      $display("mismatch time %0t signal vga_hsync low clocks expected %0d actual %0d",
               $time, c_hs_clks, $sampled(hs_low));
    end

  a_de_width: assert property (@(negedge clk) disable iff (!rst_n)
    (!vga_de && de_q) |-> (de_clks == c_de_clks))
    else begin
      err_sync++;
      $display("mismatch time %0t signal vga_de high clocks expected %0d actual %0d",
               $time, c_de_clks, $sampled(de_clks));
    end

  a_vsync_width: assert property (@(negedge clk) disable iff (!rst_n)
    vs_rise |-> (vs_low == c_vs_clks))
    else begin
      err_sync++;
      $display("mismatch time %0t signal vga_vsync low clocks expected %0d actual %0d",
               $time, c_vs_clks, $sampled(vs_low));
    end

  a_frame_lines: assert property (@(negedge clk) disable iff (!rst_n)
    vs_rise |-> (line_cnt == `V_VISIBLE))
    else begin
      err_sync++;
      $display("mismatch time %0t signal vga_de lines per frame expected %0d actual %0d",
               $time, `V_VISIBLE, $sampled(line_cnt));
    end

  a_picture: assert property (@(negedge clk) disable iff (!rst_n)
    (check_pic && vga_de && in_img) |-> (rgb == exp_pxl))
    else begin
      err_pic++;
      $display("mismatch time %0t signal rgb at row %0d col %0d expected %h actual %h",
               $time, $sampled(cur_row), $sampled(cur_col), $sampled(exp_pxl), $sampled(rgb));
    end

  a_border: assert property (@(negedge clk) disable iff (!rst_n)
    (!vga_de || !in_img) |-> (rgb == 12'h000))
    else begin
      err_border++;
      $display("mismatch time %0t signal rgb outside image expected %h actual %h",
               $time, 12'h000, $sampled(rgb));
    end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [7:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[6:0], lfsr_q[0]};   // one step per bit
    end
  endtask

  // one pclk period, data changes while pclk is low
  task automatic send_byte(input logic h, input logic [7:0] b);
    cam_pclk = 1'b0;
    cam_href = h;
    cam_data = b;
    repeat (4) @(negedge clk);
    cam_pclk = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  // href low stretch carrying junk of random length
  task automatic send_gap();
    logic [7:0] n;
    logic [7:0] junk;
    int         i;
    rand_bits(3, n);
    for (i = 0; i < 3 + int'(n); i++) begin
      rand_bits(8, junk);
      send_byte(1'b0, junk);
    end
  endtask

  task automatic send_frame();
    logic [7:0] b_hi;
    logic [7:0] b_lo;
    logic [7:0] junk;
    int         r;
    int         c;
    int         i;
    cam_vsync = 1'b1;
    for (i = 0; i < 4; i++) begin
      rand_bits(8, junk);
      send_byte(1'b0, junk);
    end
    cam_vsync = 1'b0;
    for (r = 0; r < `IMG_ROWS; r++) begin
      send_gap();
      for (c = 0; c < `IMG_COLS; c++) begin
        rand_bits(8, b_hi);
        rand_bits(8, b_lo);
        send_byte(1'b1, b_hi);
        send_byte(1'b1, b_lo);
        model[r][c] = '{red: b_hi[3:0], green: b_lo[7:4], blue: b_lo[3:0]};
      end
    end
    send_gap();   // lets the last write land
  endtask

  task automatic wait_vsync_rise(input int max_clks, output bit ok);
    logic prev;
    int   n;
    prev = vga_vsync;
    ok   = 1'b0;
    n    = 0;
    while (!ok && n < max_clks) begin
      @(negedge clk);
      if (vga_vsync && !prev) ok = 1'b1;
      prev = vga_vsync;
      n++;
    end
    if (!ok) begin
      err_timeout++;
      $display("timeout: vga_vsync did not rise within %0d clocks", max_clks);
    end
  endtask

  // two camera frames, each checked over the next full vga frame
  task automatic run_checks();
    bit ok;
    int f;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    for (f = 0; f < 2; f++) begin
      send_frame();
      wait_vsync_rise(c_vs_timeout, ok);
      if (!ok) return;
      check_pic = 1'b1;
      wait_vsync_rise(c_vs_timeout, ok);
      check_pic = 1'b0;
      if (!ok) return;
    end
    assert (pic_clks == c_pic_clks) else begin
      err_cover++;
      $display("picture check covered %0d clocks instead of %0d", pic_clks, c_pic_clks);
    end
  endtask

  task automatic finish_run();
    int total;
    total = err_reset + err_sync + err_pic + err_border + err_cover + err_timeout;
    $display("errors: reset %0d sync %0d picture %0d border %0d coverage %0d timeout %0d",
             err_reset, err_sync, err_pic, err_border, err_cover, err_timeout);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  initial begin
    run_checks();
    finish_run();
  end

endmodule

/* hdl/top_ov7670.sv */
// top level joining ov7670 capture, frame buffer and vga output
`include "ov_cfg.svh"

module top_ov7670 (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cam_pclk,
  input  logic       cam_href,
  input  logic       cam_vsync,
  input  logic [7:0] cam_data,
  output logic [3:0] vga_red,
  output logic [3:0] vga_green,
  output logic [3:0] vga_blue,
  output logic       vga_hsync,
  output logic       vga_vsync,
  output logic       vga_de
);

  cam_pkg::buf_wr_t     cap_wr;       // capture to buffer
  logic [`NB_ADDR-1:0]  fb_rd_addr;
  cam_pkg::rgb444_t     fb_pxl;
  vga_pkg::vga_timing_t vga_tim;
  vga_pkg::vga_out_t    vga_out;

  ov7670_capture i_capture (
    .clk   (clk),
    .rst_n (rst_n),
    .pclk  (cam_pclk),
    .href  (cam_href),
    .vsync (cam_vsync),
    .data  (cam_data),
    .wr    (cap_wr)
  );

  frame_buffer i_fb (
    .clk     (clk),
    .wr      (cap_wr),
    .rd_addr (fb_rd_addr),
    .rd_pxl  (fb_pxl)
  );

  vga_sync i_vga_sync (.clk(clk), .rst_n(rst_n), .tim(vga_tim));

  vga_display i_display (
    .clk     (clk),
    .rst_n   (rst_n),
    .tim     (vga_tim),
    .rd_addr (fb_rd_addr),
    .rd_pxl  (fb_pxl),
    .vout    (vga_out)
  );

  // split the output bundle onto the pins
  assign vga_red   = vga_out.red;
  assign vga_green = vga_out.green;
  assign vga_blue  = vga_out.blue;
  assign vga_hsync = vga_out.hsync;
  assign vga_vsync = vga_out.vsync;
  assign vga_de    = vga_out.de;

endmodule

/* hdl/vga_display.sv */
// vga display that reads the frame buffer at the beam position and drives colour
`include "ov_cfg.svh"

module vga_display (
  input  logic                 clk,
  input  logic                 rst_n,
  input  vga_pkg::vga_timing_t tim,
  output logic [`NB_ADDR-1:0]  rd_addr,
  input  cam_pkg::rgb444_t     rd_pxl,
  output vga_pkg::vga_out_t    vout
);

  logic in_img;     // beam inside the 80x60 picture
  logic in_img_d;
  logic vis_d;
  logic hs_d;
  logic vs_d;

  assign in_img = (tim.col < `IMG_COLS) && (tim.row < `IMG_ROWS);

  // picture sits 1:1 in the top left corner
  assign rd_addr = in_img ? `NB_ADDR'(tim.row * `IMG_COLS + tim.col) : '0;

  // first stage, wait for the buffer read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_img_d <= 1'b0;
      vis_d    <= 1'b0;
      hs_d     <= 1'b1;
      vs_d     <= 1'b1;
    end else begin
      in_img_d <= in_img;
      vis_d    <= tim.visible;
      hs_d     <= tim.hsync;
      vs_d     <= tim.vsync;
    end
  end

  // second stage, output register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vout.red   <= '0;
      vout.green <= '0;
      vout.blue  <= '0;
      vout.hsync <= 1'b1;
      vout.vsync <= 1'b1;
      vout.de    <= 1'b0;
    end else begin
      if (in_img_d && vis_d) begin
        vout.red   <= rd_pxl.red;
        vout.green <= rd_pxl.green;
        vout.blue  <= rd_pxl.blue;
      end else begin          // black border and blanking
        vout.red   <= '0;
        vout.green <= '0;
        vout.blue  <= '0;
      end
      vout.hsync <= hs_d;
      vout.vsync <= vs_d;
      vout.de    <= vis_d;
    end
  end

endmodule

/* hdl/vga_sync.sv */
// vga 640x480 timing generator with pixel tick, counters and sync pulses
`include "ov_cfg.svh"

module vga_sync (
  input  logic                clk,
  input  logic                rst_n,
  output vga_pkg::vga_timing_t tim
);

  localparam int c_nb_div   = $clog2(`CLKS_PER_PXL);
  localparam int c_hs_start = `H_VISIBLE + `H_FPORCH;
  localparam int c_hs_end   = c_hs_start + `H_SYNC;
  localparam int c_vs_start = `V_VISIBLE + `V_FPORCH;
  localparam int c_vs_end   = c_vs_start + `V_SYNC;

  logic [c_nb_div-1:0] div_cnt;
  logic                new_pxl;
  logic [`NB_COL-1:0]  col;
  logic [`NB_COL-1:0]  col_nxt;
  logic [`NB_ROW-1:0]  row;
  logic [`NB_ROW-1:0]  row_nxt;
  logic                hsync;
  logic                vsync;
  logic                visible;

  // position after the next pixel tick
  always_comb begin
    col_nxt = col + 1'b1;
    row_nxt = row;
    if (col == `H_TOTAL - 1) begin
      col_nxt = '0;
      row_nxt = (row == `V_TOTAL - 1) ? '0 : row + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      new_pxl <= 1'b0;
      col     <= `NB_COL'(`H_TOTAL - 1);  // first tick lands on 0,0
      row     <= `NB_ROW'(`V_TOTAL - 1);
      hsync   <= 1'b1;
      vsync   <= 1'b1;
      visible <= 1'b0;
    end else begin
      div_cnt <= (div_cnt == `CLKS_PER_PXL - 1) ? '0 : div_cnt + 1'b1;
      new_pxl <= (div_cnt == `CLKS_PER_PXL - 1);
      if (new_pxl) begin
        col     <= col_nxt;
        row     <= row_nxt;
        hsync   <= !((col_nxt >= c_hs_start) && (col_nxt < c_hs_end));
        vsync   <= !((row_nxt >= c_vs_start) && (row_nxt < c_vs_end));
        visible <= (col_nxt < `H_VISIBLE) && (row_nxt < `V_VISIBLE);
      end
    end
  end

  assign tim = '{visible: visible, new_pxl: new_pxl, hsync: hsync,
                 vsync: vsync, col: col, row: row};

  a_col_range: assert property (@(posedge clk) disable iff (!rst_n)
    col < `H_TOTAL)
    else $error("vga col %0d out of range", col);

  a_row_range: assert property (@(posedge clk) disable iff (!rst_n)
    row < `V_TOTAL)
    else $error("vga row %0d out of range", row);

endmodule

/* hdl/frame_buffer.sv */
// frame buffer as a simple dual port ram with one write and one registered read port
`include "ov_cfg.svh"

module frame_buffer (
  input  logic                clk,
  input  cam_pkg::buf_wr_t    wr,
  input  logic [`NB_ADDR-1:0] rd_addr,
  output cam_pkg::rgb444_t    rd_pxl
);

  // one word per captured pixel
  logic [`NB_PXL-1:0] mem [`IMG_PXLS];

  // write side, from capture
  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // read side, one clock of latency
  always_ff @(posedge clk) begin
    rd_pxl <= cam_pkg::rgb444_t'(mem[rd_addr]);
  end

  // addresses past the image would land beyond the array
  a_wr_addr: assert property (@(posedge clk)
    wr.we |-> (wr.addr < `IMG_PXLS))
    else $error("buffer write to addr %0d past %0d words", wr.addr, `IMG_PXLS);

endmodule

/* hdl/ov7670_capture.sv */
// ov7670 capture block that samples the camera bus and writes rgb444 pixels to the buffer
`include "ov_cfg.svh"

module ov7670_capture (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             pclk,
  input  logic             href,
  input  logic             vsync,
  input  logic [7:0]       data,
  output cam_pkg::buf_wr_t wr
);

  logic [1:0]           pclk_sync;   // two flop synchronisers
  logic [1:0]           href_sync;
  logic [1:0]           vsync_sync;
  logic [7:0]           data_s1;
  logic [7:0]           data_s2;

  logic                 pclk_d;
  logic                 pclk_rise;   // registered rising edge of pclk
  logic                 href_e;
  logic                 vsync_e;
  logic [7:0]           data_e;

  cam_pkg::cap_state_t  state;
  logic [`NB_ADDR-1:0]  addr_cnt;    // next buffer address
  logic [3:0]           red_nib;

  logic                 wr_we;
  logic [`NB_ADDR-1:0]  wr_addr;
  cam_pkg::rgb444_t     wr_data;

  // synchroniser and edge stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pclk_sync  <= '0;
      href_sync  <= '0;
      vsync_sync <= '0;
      pclk_d     <= 1'b0;
      pclk_rise  <= 1'b0;
      href_e     <= 1'b0;
      vsync_e    <= 1'b0;
    end else begin
      pclk_sync  <= {pclk_sync[0], pclk};
      href_sync  <= {href_sync[0], href};
      vsync_sync <= {vsync_sync[0], vsync};
      pclk_d     <= pclk_sync[1];
      pclk_rise  <= pclk_sync[1] & ~pclk_d;
      href_e     <= href_sync[1];   // kept in step with pclk_rise
      vsync_e    <= vsync_sync[1];
    end
  end

  // data bus follows the same stages
  always_ff @(posedge clk) begin
    data_s1 <= data;
    data_s2 <= data_s1;
    data_e  <= data_s2;
  end

  // byte pairing fsm and address counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= cam_pkg::wait_frame;
      addr_cnt <= '0;
      wr_we    <= 1'b0;
    end else begin
      wr_we <= 1'b0;
      if (vsync_e) begin               // new frame, start over
        state    <= cam_pkg::wait_frame;
        addr_cnt <= '0;
      end else begin
        unique case (state)
          cam_pkg::wait_frame: state <= cam_pkg::byte_hi;
          cam_pkg::byte_hi: begin
            if (pclk_rise && href_e) state <= cam_pkg::byte_lo;
          end
          cam_pkg::byte_lo: begin
            if (!href_e) begin
              state <= cam_pkg::byte_hi;   // line ended mid pixel
            end else if (pclk_rise) begin
              state <= cam_pkg::byte_hi;
              if (addr_cnt < `IMG_PXLS) begin  // no wrap past the image
                wr_we    <= 1'b1;
                addr_cnt <= addr_cnt + 1'b1;
              end
            end
          end
          default: state <= cam_pkg::wait_frame;
        endcase
      end
    end
  end

  // pixel assembly, write payload
  always_ff @(posedge clk) begin
    if (pclk_rise && href_e) begin
      if (state == cam_pkg::byte_hi) red_nib <= data_e[3:0];
      if (state == cam_pkg::byte_lo) begin
        wr_addr <= addr_cnt;
        wr_data <= '{red: red_nib, green: data_e[7:4], blue: data_e[3:0]};
      end
    end
  end

  assign wr = '{we: wr_we, addr: wr_addr, data: wr_data};

  a_we_in_image: assert property (@(posedge clk) disable iff (!rst_n)
    wr.we |-> (wr.addr < `IMG_PXLS))
    else $error("capture wrote outside the image at addr %0d", wr.addr);

endmodule

/* hdl/vga_pkg.sv */
// display side types for vga timing and the colour output bundle
`include "ov_cfg.svh"

package vga_pkg;

  // timing from vga_sync, all fields registered
  typedef struct packed {
    logic               visible;  // inside 640x480
    logic               new_pxl;  // one clk in four
    logic               hsync;    // active low
    logic               vsync;    // active low
    logic [`NB_COL-1:0] col;
    logic [`NB_ROW-1:0] row;
  } vga_timing_t;

  // what goes out to the monitor
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
    logic       hsync;
    logic       vsync;
    logic       de;     // data enable, delayed visible
  } vga_out_t;

endpackage

/* hdl/cam_pkg.sv */
// camera side types for pixel data, buffer writes and the capture fsm
`include "ov_cfg.svh"

package cam_pkg;

  // one buffer word, red in the top nibble
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb444_t;

  // write port of the frame buffer, driven by capture
  typedef struct packed {
    logic                we;
    logic [`NB_ADDR-1:0] addr;
    rgb444_t             data;
  } buf_wr_t;

  // capture fsm
  //   wait_frame  hold until vsync drops
  //   byte_hi     expecting the byte with red
  //   byte_lo     expecting the byte with green and blue
  typedef enum logic [1:0] {
    wait_frame,
    byte_hi,
    byte_lo
  } cap_state_t;

endpackage

/* hdl/ov_cfg.svh */
// configuration macros for the ov7670 capture and vga display project
`ifndef OV_CFG_SVH
`define OV_CFG_SVH

// captured image, qqvga halved
`define IMG_COLS      80
`define IMG_ROWS      60
`define IMG_PXLS      (`IMG_COLS * `IMG_ROWS)   // frame buffer words
`define NB_ADDR       13                        // 4800 words fit in 2^13
`define NB_PXL        12                        // rgb444 word

// horizontal timing in pixels
`define H_VISIBLE     640
`define H_FPORCH      16
`define H_SYNC        96
`define H_BPORCH      48
`define H_TOTAL       (`H_VISIBLE + `H_FPORCH + `H_SYNC + `H_BPORCH)

// vertical timing in lines
`define V_VISIBLE     480
`define V_FPORCH      10
`define V_SYNC        2
`define V_BPORCH      33
`define V_TOTAL       (`V_VISIBLE + `V_FPORCH + `V_SYNC + `V_BPORCH)

`define CLKS_PER_PXL  4     // clk runs at four times the pixel rate

`define NB_COL        10    // up to 800 columns
`define NB_ROW        10    // up to 525 rows

`endif
